// ==== design/mrd_consts.svh ====
// widths, frame limit and Q2.15 twiddle constants, included by the package and every module
`ifndef MRD_CONSTS_SVH
`define MRD_CONSTS_SVH

// sample and accumulator widths
`define MRD_DW 18
`define MRD_ACCW 36

// bin width out of the core, three guard bits above a sample
`define MRD_BINW (`MRD_DW + 3)

// largest supported frame and block exponent width
`define MRD_MAXN 5
`define MRD_EXPW 4

// twiddle fraction bits
`define MRD_FRAC 15

// unity in Q2.15, exact for the radix-2 and radix-4 tables
`define MRD_ONE (18'sd32768)

// radix-3, angle 2pi/3
`define MRD_C3_1 (-18'sd16384)
`define MRD_S3_1 (18'sd28378)

// radix-5, angles 2pi/5 and 4pi/5
`define MRD_C5_1 (18'sd10126)
`define MRD_S5_1 (18'sd31164)
`define MRD_C5_2 (-18'sd26510)
`define MRD_S5_2 (18'sd19261)

`endif

// ==== design/mrd_pkg.sv ====
// shared data types of the DFT engine, referenced by scoped name from the RTL and testbench
`include "mrd_consts.svh"

package mrd_pkg;

	// complex component of one input or output sample
	typedef logic signed [`MRD_DW-1:0] sample_t;

	// full precision sum of products
	typedef logic signed [`MRD_ACCW-1:0] acc_t;

	// frame size field as carried by the input stream
	typedef logic [5:0] size_t;

	// sample index, bin index and point count
	typedef logic [2:0] idx_t;

	// shared block exponent of an output frame
	typedef logic [`MRD_EXPW-1:0] exp_t;

	// control sequence of the decode stage
	typedef enum logic [1:0]
	{
		IDLE,
		LOAD,
		CALC,
		DRAIN
	} fsm_t;

endpackage

// ==== design/mrd_ctrl_fsm.sv ====
// decode stage: accepts an input frame, stores its samples and steps the core through the bins
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_ctrl_fsm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sink_valid,
	input  logic              sink_sop,
	input  logic              sink_eop,
	input  mrd_pkg::sample_t  sink_real,
	input  mrd_pkg::sample_t  sink_imag,
	input  mrd_pkg::size_t    size,
	input  logic              inverse,
	input  logic              frame_done,
	output logic              sink_ready,
	output mrd_pkg::idx_t     n_pts,
	output logic              inv,
	output logic              calc_en,
	output mrd_pkg::idx_t     bin_k,
	output mrd_pkg::sample_t  samp_real [`MRD_MAXN],
	output mrd_pkg::sample_t  samp_imag [`MRD_MAXN]
);

	mrd_pkg::fsm_t state;
	mrd_pkg::idx_t cnt;
	mrd_pkg::idx_t wr_idx;
	logic          size_ok;
	logic          size_in_range;
	logic          sop_beat;
	logic          accept;

	// input side is open while a frame is being collected
	assign sink_ready = (state == mrd_pkg::IDLE) || (state == mrd_pkg::LOAD);
	assign calc_en = (state == mrd_pkg::CALC);

	// beats outside a frame are consumed and dropped
	assign sop_beat = sink_valid && sink_sop && (state == mrd_pkg::IDLE);
	assign accept = sop_beat || (sink_valid && (state == mrd_pkg::LOAD));
	assign wr_idx = (state == mrd_pkg::IDLE) ? '0 : cnt;

	assign size_in_range = (size >= 6'd2) && (size <= 6'(`MRD_MAXN));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= mrd_pkg::IDLE;
			cnt <= '0;
			bin_k <= '0;
			n_pts <= '0;
			inv <= 1'b0;
			size_ok <= 1'b0;
		end
		else
		begin
			case (state)
				mrd_pkg::IDLE:
				begin
					if (sop_beat)
					begin
						n_pts <= size[2:0];
						inv <= inverse;
						size_ok <= size_in_range;
						cnt <= 3'd1;
						// a one-beat frame never matches a legal size
						if (!sink_eop)
							state <= mrd_pkg::LOAD;
					end
				end
				mrd_pkg::LOAD:
				begin
					if (accept)
					begin
						if (sink_eop)
						begin
							if (size_ok && (cnt == n_pts - 3'd1))
							begin
								state <= mrd_pkg::CALC;
								bin_k <= '0;
							end
							else
								state <= mrd_pkg::IDLE;
						end
						// saturate so an overlong frame still mismatches at eop
						else if (cnt != 3'd7)
							cnt <= cnt + 3'd1;
					end
				end
				mrd_pkg::CALC:
				begin
					if (bin_k == n_pts - 3'd1)
						state <= mrd_pkg::DRAIN;
					else
						bin_k <= bin_k + 3'd1;
				end
				mrd_pkg::DRAIN:
				begin
					// hold off new frames until the output has drained
					if (frame_done)
						state <= mrd_pkg::IDLE;
				end
				default:
					state <= mrd_pkg::IDLE;
			endcase
		end
	end

	// sample register file, written by arrival index
	always_ff @(posedge clk)
	begin
		if (accept && (wr_idx < 3'(`MRD_MAXN)))
		begin
			samp_real[wr_idx] <= sink_real;
			samp_imag[wr_idx] <= sink_imag;
		end
	end

endmodule

// ==== design/mrd_rdx2345.sv ====
// execute stage: computes one DFT bin per cycle from the stored frame and the twiddle table
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_rdx2345 (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        calc_en,
	input  mrd_pkg::idx_t               bin_k,
	input  mrd_pkg::idx_t               n_pts,
	input  logic                        inv,
	input  mrd_pkg::sample_t            samp_real [`MRD_MAXN],
	input  mrd_pkg::sample_t            samp_imag [`MRD_MAXN],
	output logic                        bin_valid,
	output logic                        bin_last,
	output logic signed [`MRD_BINW-1:0] bin_real,
	output logic signed [`MRD_BINW-1:0] bin_imag
);

	mrd_pkg::acc_t term_re [`MRD_MAXN];
	mrd_pkg::acc_t term_im [`MRD_MAXN];
	mrd_pkg::acc_t sum_re;
	mrd_pkg::acc_t sum_im;
	mrd_pkg::acc_t shr_re;
	mrd_pkg::acc_t shr_im;

	// twiddle exponent n*k reduced mod N
	function automatic mrd_pkg::idx_t tw_idx(input mrd_pkg::idx_t n, input mrd_pkg::idx_t k,
		input mrd_pkg::idx_t npts);
		logic [5:0] prod;
		prod = 6'(n) * 6'(k);
		if (npts == '0)
			return '0;
		return mrd_pkg::idx_t'(prod % 6'(npts));
	endfunction

	// cos(2*pi*m/N)
	function automatic mrd_pkg::sample_t tw_cos(input mrd_pkg::idx_t npts,
		input mrd_pkg::idx_t m);
		case ({npts, m})
			{3'd2, 3'd1}: return -`MRD_ONE;
			{3'd3, 3'd1},
			{3'd3, 3'd2}: return `MRD_C3_1;
			{3'd4, 3'd1},
			{3'd4, 3'd3}: return '0;
			{3'd4, 3'd2}: return -`MRD_ONE;
			{3'd5, 3'd1},
			{3'd5, 3'd4}: return `MRD_C5_1;
			{3'd5, 3'd2},
			{3'd5, 3'd3}: return `MRD_C5_2;
			default: return `MRD_ONE;
		endcase
	endfunction

	// sin(2*pi*m/N), odd around m = N/2
	function automatic mrd_pkg::sample_t tw_sin(input mrd_pkg::idx_t npts,
		input mrd_pkg::idx_t m);
		case ({npts, m})
			{3'd3, 3'd1}: return `MRD_S3_1;
			{3'd3, 3'd2}: return -`MRD_S3_1;
			{3'd4, 3'd1}: return `MRD_ONE;
			{3'd4, 3'd3}: return -`MRD_ONE;
			{3'd5, 3'd1}: return `MRD_S5_1;
			{3'd5, 3'd2}: return `MRD_S5_2;
			{3'd5, 3'd3}: return -`MRD_S5_2;
			{3'd5, 3'd4}: return -`MRD_S5_1;
			default: return '0;
		endcase
	endfunction

	// x[n] * (C - jS), S negated for the inverse transform
	always_comb
	begin : twiddle_mul
		mrd_pkg::idx_t m;
		mrd_pkg::sample_t c;
		mrd_pkg::sample_t s;
		for (int n = 0; n < `MRD_MAXN; n++)
		begin
			m = tw_idx(mrd_pkg::idx_t'(n), bin_k, n_pts);
			c = tw_cos(n_pts, m);
			s = tw_sin(n_pts, m);
			if (inv)
				s = -s;
			if (mrd_pkg::idx_t'(n) < n_pts)
			begin
				term_re[n] = mrd_pkg::acc_t'(samp_real[n]) * mrd_pkg::acc_t'(c)
					+ mrd_pkg::acc_t'(samp_imag[n]) * mrd_pkg::acc_t'(s);
				term_im[n] = mrd_pkg::acc_t'(samp_imag[n]) * mrd_pkg::acc_t'(c)
					- mrd_pkg::acc_t'(samp_real[n]) * mrd_pkg::acc_t'(s);
			end
			else
			begin
				term_re[n] = '0;
				term_im[n] = '0;
			end
		end
	end

	// adder tree over the five product slots
	assign sum_re = (term_re[0] + term_re[1]) + (term_re[2] + term_re[3]) + term_re[4];
	assign sum_im = (term_im[0] + term_im[1]) + (term_im[2] + term_im[3]) + term_im[4];

	// drop the Q2.15 fraction, floor rounding
	assign shr_re = sum_re >>> `MRD_FRAC;
	assign shr_im = sum_im >>> `MRD_FRAC;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bin_valid <= 1'b0;
			bin_last <= 1'b0;
		end
		else
		begin
			bin_valid <= calc_en;
			bin_last <= calc_en && (bin_k == n_pts - 3'd1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (calc_en)
		begin
			bin_real <= shr_re[`MRD_BINW-1:0];
			bin_imag <= shr_im[`MRD_BINW-1:0];
		end
	end

endmodule

// ==== design/mrd_out_norm.sv ====
// result stage: buffers the bins, picks the block exponent and streams the scaled frame out
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_out_norm (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        bin_valid,
	input  logic                        bin_last,
	input  logic signed [`MRD_BINW-1:0] bin_real,
	input  logic signed [`MRD_BINW-1:0] bin_imag,
	output logic                        source_valid,
	output logic                        source_sop,
	output logic                        source_eop,
	output mrd_pkg::sample_t            source_real,
	output mrd_pkg::sample_t            source_imag,
	output mrd_pkg::exp_t               source_exp,
	output logic                        frame_done
);

	localparam int HEAD = `MRD_BINW - `MRD_DW;

	logic signed [`MRD_BINW-1:0] store_re [`MRD_MAXN];
	logic signed [`MRD_BINW-1:0] store_im [`MRD_MAXN];
	mrd_pkg::idx_t wr_idx;
	mrd_pkg::idx_t rd_idx;
	mrd_pkg::idx_t last_idx;
	mrd_pkg::exp_t hr;
	mrd_pkg::exp_t hr_next;
	mrd_pkg::exp_t shift;
	logic          play;

	// smallest s so that v >>> s fits a sample word
	function automatic mrd_pkg::exp_t need_shift(input logic signed [`MRD_BINW-1:0] v);
		logic signed [`MRD_BINW-1:0] top;
		mrd_pkg::exp_t s;
		s = '0;
		for (int i = 1; i <= HEAD; i++)
		begin
			top = v >>> (`MRD_DW + i - 2);
			if (!((top == '0) || (top == '1)))
				s = mrd_pkg::exp_t'(i);
		end
		return s;
	endfunction

	function automatic mrd_pkg::sample_t scale(input logic signed [`MRD_BINW-1:0] v,
		input mrd_pkg::exp_t s);
		logic signed [`MRD_BINW-1:0] t;
		t = v >>> s;
		return t[`MRD_DW-1:0];
	endfunction

	// running maximum headroom, restarted with bin 0
	always_comb
	begin : headroom
		mrd_pkg::exp_t base;
		mrd_pkg::exp_t nr;
		mrd_pkg::exp_t ni;
		base = (wr_idx == '0) ? '0 : hr;
		nr = need_shift(bin_real);
		ni = need_shift(bin_imag);
		hr_next = base;
		if (nr > hr_next)
			hr_next = nr;
		if (ni > hr_next)
			hr_next = ni;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_idx <= '0;
			rd_idx <= '0;
			last_idx <= '0;
			hr <= '0;
			shift <= '0;
			play <= 1'b0;
			source_valid <= 1'b0;
			source_sop <= 1'b0;
			source_eop <= 1'b0;
		end
		else
		begin
			if (bin_valid)
			begin
				hr <= hr_next;
				if (bin_last)
				begin
					// exponent fixed once the whole frame is known
					shift <= hr_next;
					last_idx <= wr_idx;
					wr_idx <= '0;
					rd_idx <= '0;
					play <= 1'b1;
				end
				else
					wr_idx <= wr_idx + 3'd1;
			end
			source_valid <= play;
			source_sop <= play && (rd_idx == '0);
			source_eop <= play && (rd_idx == last_idx);
			if (play)
			begin
				rd_idx <= rd_idx + 3'd1;
				if (rd_idx == last_idx)
					play <= 1'b0;
			end
		end
	end

	// bin buffer and output words
	always_ff @(posedge clk)
	begin
		if (bin_valid)
		begin
			store_re[wr_idx] <= bin_real;
			store_im[wr_idx] <= bin_imag;
		end
		if (play)
		begin
			source_real <= scale(store_re[rd_idx], shift);
			source_imag <= scale(store_im[rd_idx], shift);
			source_exp <= shift;
		end
	end

	// releases the decode stage with the last output beat
	assign frame_done = source_valid && source_eop;

endmodule

// ==== design/top_mixed_radix_dft.sv ====
// top level of the mixed-radix DFT engine: decode, execute and result stages wired together
`timescale 1ns/1ps
`include "mrd_consts.svh"

module top_mixed_radix_dft (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             sink_valid,
	output logic             sink_ready,
	input  logic             sink_sop,
	input  logic             sink_eop,
	input  mrd_pkg::sample_t sink_real,
	input  mrd_pkg::sample_t sink_imag,
	input  mrd_pkg::size_t   size,
	input  logic             inverse,
	output logic             source_valid,
	output logic             source_sop,
	output logic             source_eop,
	output mrd_pkg::sample_t source_real,
	output mrd_pkg::sample_t source_imag,
	output mrd_pkg::exp_t    source_exp
);

	// decode to execute
	mrd_pkg::idx_t    n_pts;
	mrd_pkg::idx_t    bin_k;
	logic             inv;
	logic             calc_en;
	mrd_pkg::sample_t samp_real [`MRD_MAXN];
	mrd_pkg::sample_t samp_imag [`MRD_MAXN];

	// execute to result
	logic                        bin_valid;
	logic                        bin_last;
	logic signed [`MRD_BINW-1:0] bin_real;
	logic signed [`MRD_BINW-1:0] bin_imag;

	// result back to decode
	logic frame_done;

	mrd_ctrl_fsm ctrl0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.sink_valid (sink_valid),
		.sink_sop   (sink_sop),
		.sink_eop   (sink_eop),
		.sink_real  (sink_real),
		.sink_imag  (sink_imag),
		.size       (size),
		.inverse    (inverse),
		.frame_done (frame_done),
		.sink_ready (sink_ready),
		.n_pts      (n_pts),
		.inv        (inv),
		.calc_en    (calc_en),
		.bin_k      (bin_k),
		.samp_real  (samp_real),
		.samp_imag  (samp_imag)
	);

	mrd_rdx2345 rdx0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.calc_en   (calc_en),
		.bin_k     (bin_k),
		.n_pts     (n_pts),
		.inv       (inv),
		.samp_real (samp_real),
		.samp_imag (samp_imag),
		.bin_valid (bin_valid),
		.bin_last  (bin_last),
		.bin_real  (bin_real),
		.bin_imag  (bin_imag)
	);

	mrd_out_norm norm0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.bin_valid    (bin_valid),
		.bin_last     (bin_last),
		.bin_real     (bin_real),
		.bin_imag     (bin_imag),
		.source_valid (source_valid),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.source_real  (source_real),
		.source_imag  (source_imag),
		.source_exp   (source_exp),
		.frame_done   (frame_done)
	);

endmodule

// ==== sim/mrd_props.sv ====
// stream protocol assertions for the DFT engine, bound into the top level by the bind below
`timescale 1ns/1ps

module mrd_props (
	input logic          clk,
	input logic          rst_n,
	input logic          sink_ready,
	input logic          source_valid,
	input logic          source_sop,
	input mrd_pkg::exp_t source_exp
);

	// output framing, sop opens a frame after an idle cycle
	sop_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
		source_sop |-> source_valid && !$past(source_valid))
		else $error("source_sop seen without source_valid or inside a frame");

	// one exponent per output frame
	exp_held_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		(source_valid && !source_sop) |-> $stable(source_exp))
		else $error("source_exp changed inside an output frame");

	// input side closed while a frame drains
	no_accept_while_draining: assert property (@(posedge clk) disable iff (!rst_n)
		source_valid |-> !sink_ready)
		else $error("sink_ready high while source_valid is high");

	valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(source_valid))
		else $error("source_valid is unknown after reset");

endmodule

bind top_mixed_radix_dft mrd_props props0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.sink_ready   (sink_ready),
	.source_valid (source_valid),
	.source_sop   (source_sop),
	.source_exp   (source_exp)
);

// ==== sim/tb_top.sv ====
// directed testbench for the mixed-radix DFT engine, the simulation top for Verilator
`timescale 1ns/1ps
`include "mrd_consts.svh"

module tb_top;

	localparam int SEED = 87;
	// impulse 4, forward 8, inverse 8, overflow 1, bad size 2
	localparam int NUM_FRAMES = 23;
	localparam int TIMEOUT_CYC = 40 * NUM_FRAMES + 100;

	logic             clk;
	logic             rst_n;
	logic             sink_valid;
	logic             sink_ready;
	logic             sink_sop;
	logic             sink_eop;
	mrd_pkg::sample_t sink_real;
	mrd_pkg::sample_t sink_imag;
	mrd_pkg::size_t   size;
	logic             inverse;
	logic             source_valid;
	logic             source_sop;
	logic             source_eop;
	mrd_pkg::sample_t source_real;
	mrd_pkg::sample_t source_imag;
	mrd_pkg::exp_t    source_exp;

	int          cyc = 0;
	int          frames_seen = 0;
	int          eop_cyc;
	int          checks;
	int          errors;
	logic [31:0] rng_state;

	// frame under test and its expected output
	longint x_re [8];
	longint x_im [8];
	longint ref_re [`MRD_MAXN];
	longint ref_im [`MRD_MAXN];
	int     ref_exp;
	longint cos_tab [6][`MRD_MAXN];
	longint sin_tab [6][`MRD_MAXN];
	longint saved_re [8][`MRD_MAXN];
	longint saved_im [8][`MRD_MAXN];

	// captured output beats
	mrd_pkg::sample_t cap_re [$];
	mrd_pkg::sample_t cap_im [$];
	mrd_pkg::exp_t    cap_exp [$];
	logic             cap_sop [$];
	logic             cap_eop [$];
	int               cap_cyc [$];

	top_mixed_radix_dft dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.sink_real    (sink_real),
		.sink_imag    (sink_imag),
		.size         (size),
		.inverse      (inverse),
		.source_valid (source_valid),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.source_real  (source_real),
		.source_imag  (source_imag),
		.source_exp   (source_exp)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (rst_n && (source_valid === 1'b1))
		begin
			cap_re.push_back(source_real);
			cap_im.push_back(source_imag);
			cap_exp.push_back(source_exp);
			cap_sop.push_back(source_sop);
			cap_eop.push_back(source_eop);
			cap_cyc.push_back(cyc);
			if (source_eop === 1'b1)
				frames_seen++;
		end
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// 16-bit signed sample, well inside the 18-bit range
	function automatic longint rand_sample();
		logic [31:0] r;
		r = xorshift32();
		return longint'($signed(r[15:0]));
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want);
		end
	endtask

	// cos and sin of 2*pi*m/N in Q2.15
	task automatic load_twiddles();
		for (int n = 0; n < 6; n++)
		begin
			for (int m = 0; m < `MRD_MAXN; m++)
			begin
				cos_tab[n][m] = 0;
				sin_tab[n][m] = 0;
			end
			cos_tab[n][0] = longint'(`MRD_ONE);
		end
		cos_tab[2][1] = -longint'(`MRD_ONE);
		cos_tab[3][1] = longint'(`MRD_C3_1);
		cos_tab[3][2] = longint'(`MRD_C3_1);
		sin_tab[3][1] = longint'(`MRD_S3_1);
		sin_tab[3][2] = -longint'(`MRD_S3_1);
		cos_tab[4][2] = -longint'(`MRD_ONE);
		sin_tab[4][1] = longint'(`MRD_ONE);
		sin_tab[4][3] = -longint'(`MRD_ONE);
		cos_tab[5][1] = longint'(`MRD_C5_1);
		cos_tab[5][2] = longint'(`MRD_C5_2);
		cos_tab[5][3] = longint'(`MRD_C5_2);
		cos_tab[5][4] = longint'(`MRD_C5_1);
		sin_tab[5][1] = longint'(`MRD_S5_1);
		sin_tab[5][2] = longint'(`MRD_S5_2);
		sin_tab[5][3] = -longint'(`MRD_S5_2);
		sin_tab[5][4] = -longint'(`MRD_S5_1);
	endtask

	// direct N-point DFT with floor scaling, then the block exponent search
	task automatic model_dft(input int n, input bit inv_mode);
		longint raw_re [`MRD_MAXN];
		longint raw_im [`MRD_MAXN];
		longint lim;
		longint c;
		longint s;
		bit     fits;
		lim = longint'(1) << (`MRD_DW - 1);
		for (int k = 0; k < n; k++)
		begin
			raw_re[k] = 0;
			raw_im[k] = 0;
			for (int j = 0; j < n; j++)
			begin
				c = cos_tab[n][(j * k) % n];
				s = inv_mode ? -sin_tab[n][(j * k) % n] : sin_tab[n][(j * k) % n];
				raw_re[k] += x_re[j] * c + x_im[j] * s;
				raw_im[k] += x_im[j] * c - x_re[j] * s;
			end
			raw_re[k] = raw_re[k] >>> `MRD_FRAC;
			raw_im[k] = raw_im[k] >>> `MRD_FRAC;
		end
		ref_exp = 15;
		for (int e = 15; e >= 0; e--)
		begin
			fits = 1'b1;
			for (int k = 0; k < n; k++)
			begin
				if (((raw_re[k] >>> e) >= lim) || ((raw_re[k] >>> e) < -lim))
					fits = 1'b0;
				if (((raw_im[k] >>> e) >= lim) || ((raw_im[k] >>> e) < -lim))
					fits = 1'b0;
			end
			if (fits)
				ref_exp = e;
		end
		for (int k = 0; k < n; k++)
		begin
			ref_re[k] = raw_re[k] >>> ref_exp;
			ref_im[k] = raw_im[k] >>> ref_exp;
		end
	endtask

	task automatic clear_capture();
		cap_re.delete();
		cap_im.delete();
		cap_exp.delete();
		cap_sop.delete();
		cap_eop.delete();
		cap_cyc.delete();
	endtask

	// one beat per accepted cycle, eop on the last beat
	task automatic send_frame(input int n_beats, input int size_val, input bit inv_mode);
		for (int i = 0; i < n_beats; i++)
		begin
			@(negedge clk);
			sink_valid = 1'b1;
			sink_sop = (i == 0);
			sink_eop = (i == n_beats - 1);
			sink_real = mrd_pkg::sample_t'(x_re[i]);
			sink_imag = mrd_pkg::sample_t'(x_im[i]);
			size = mrd_pkg::size_t'(size_val);
			inverse = inv_mode;
			while (sink_ready !== 1'b1)
				@(negedge clk);
			@(posedge clk);
		end
		@(negedge clk);
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		eop_cyc = cyc;
	endtask

	// framing, exponent, bins and latency of the captured frame
	task automatic check_frame(input int n);
		check_val("beat count", 64'(cap_re.size()), 64'(n));
		if (cap_re.size() == n)
		begin
			for (int k = 0; k < n; k++)
			begin
				check_val("source_sop", 64'(cap_sop[k]), 64'(k == 0));
				check_val("source_eop", 64'(cap_eop[k]), 64'(k == n - 1));
				check_val("source_exp", 64'(cap_exp[k]), 64'(ref_exp));
				check_val("source_real", 64'(cap_re[k]), 64'(ref_re[k]));
				check_val("source_imag", 64'(cap_im[k]), 64'(ref_im[k]));
				check_val("output cycle", 64'(cap_cyc[k] - eop_cyc), 64'(n + 2 + k));
			end
		end
	endtask

	task automatic send_and_check(input int n, input bit inv_mode);
		int target;
		clear_capture();
		target = frames_seen + 1;
		send_frame(n, n, inv_mode);
		while (frames_seen < target)
			@(negedge clk);
		check_frame(n);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_val("sink_ready", 64'(sink_ready), 64'd1);
		check_val("source_valid", 64'(source_valid), 64'd0);
	endtask

	task automatic test_impulse();
		for (int n = 2; n <= `MRD_MAXN; n++)
		begin
			for (int j = 0; j < 8; j++)
			begin
				x_re[j] = 0;
				x_im[j] = 0;
			end
			x_re[0] = 1000;
			// flat spectrum of a unit impulse
			for (int k = 0; k < `MRD_MAXN; k++)
			begin
				ref_re[k] = 1000;
				ref_im[k] = 0;
			end
			ref_exp = 0;
			send_and_check(n, 1'b0);
		end
	endtask

	task automatic test_random_fwd();
		int f;
		for (int n = 2; n <= `MRD_MAXN; n++)
		begin
			for (int rep = 0; rep < 2; rep++)
			begin
				f = (n - 2) * 2 + rep;
				for (int j = 0; j < n; j++)
				begin
					x_re[j] = rand_sample();
					x_im[j] = rand_sample();
					saved_re[f][j] = x_re[j];
					saved_im[f][j] = x_im[j];
				end
				model_dft(n, 1'b0);
				send_and_check(n, 1'b0);
			end
		end
	endtask

	// replays the forward frames through the conjugate twiddles
	task automatic test_inverse();
		int f;
		for (int n = 2; n <= `MRD_MAXN; n++)
		begin
			for (int rep = 0; rep < 2; rep++)
			begin
				f = (n - 2) * 2 + rep;
				for (int j = 0; j < n; j++)
				begin
					x_re[j] = saved_re[f][j];
					x_im[j] = saved_im[f][j];
				end
				model_dft(n, 1'b1);
				send_and_check(n, 1'b1);
			end
		end
	endtask

	task automatic test_overflow();
		for (int j = 0; j < `MRD_MAXN; j++)
		begin
			x_re[j] = 131071;
			x_im[j] = 131071;
		end
		model_dft(`MRD_MAXN, 1'b0);
		send_and_check(`MRD_MAXN, 1'b0);
	endtask

	task automatic test_bad_size();
		int start;
		clear_capture();
		start = frames_seen;
		for (int j = 0; j < 7; j++)
		begin
			x_re[j] = rand_sample();
			x_im[j] = rand_sample();
		end
		send_frame(7, 7, 1'b0);
		for (int j = 0; j < 3; j++)
		begin
			x_re[j] = rand_sample();
			x_im[j] = rand_sample();
		end
		model_dft(3, 1'b0);
		send_frame(3, 3, 1'b0);
		while (frames_seen < start + 1)
			@(negedge clk);
		// window for a stray second frame
		repeat (12) @(negedge clk);
		check_val("frame count", 64'(frames_seen - start), 64'd1);
		check_frame(3);
	endtask

	initial
	begin
		rst_n = 1'b0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		sink_real = '0;
		sink_imag = '0;
		size = '0;
		inverse = 1'b0;
		checks = 0;
		errors = 0;
		eop_cyc = 0;
		rng_state = 32'(SEED);
		load_twiddles();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_impulse();
		test_random_fwd();
		test_inverse();
		test_overflow();
		test_bad_size();
		repeat (4) @(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		while (cyc < TIMEOUT_CYC)
			@(negedge clk);
		errors++;
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("checks %0d, errors %0d", checks, errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+design
design/mrd_pkg.sv
design/mrd_ctrl_fsm.sv
design/mrd_rdx2345.sv
design/mrd_out_norm.sv
design/top_mixed_radix_dft.sv
sim/mrd_props.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# builds the DFT engine testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_top -f list.f

status=0
./obj_dir/Vtb_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q -x -F '** PASS **' sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
